// ==== src/evg_defs.svh ====
`ifndef EVG_DEFS_SVH
`define EVG_DEFS_SVH

// Event code and prescaler widths
`define EVG_EVENT_W     8
`define EVG_PRESC_W     32

`define EVG_FIFO_DEPTH  16      // Event buffer entries

// Segmented data buffer, one byte on every odd slot
`define EVG_SEG_WORDS   32
`define EVG_SLOT_W      6       // Covers two slots per table byte

// K-characters used on the link
`define EVG_K_COMMA     8'hBC   // K28.5
`define EVG_K_SEG_START 8'h5C   // K28.2, segment start
`define EVG_K_SEG_STOP  8'h3C   // K28.1, segment stop

`endif

// ==== src/evg_pkg.sv ====
`include "evg_defs.svh"

package evg_pkg;

    // One event code on the event lane, zero means idle
    typedef logic [`EVG_EVENT_W-1:0] event_code_t;

    typedef logic [`EVG_PRESC_W-1:0] presc_t;   // Prescaler reload value

    // One transceiver word, 16 data bits plus two K flags
    typedef struct packed {
        logic [7:0] ev_byte;    // Comma or event code
        logic [7:0] seg_byte;   // Segment or distributed-bus byte
        logic       ev_is_k;    // K flag for ev_byte
        logic       seg_is_k;   // K flag for seg_byte
    } link_word_t;

    // Segmented data buffer contents, sent one byte per odd slot
    parameter logic [7:0] SEG_TABLE [0:`EVG_SEG_WORDS-1] = '{
        `EVG_K_SEG_START,                   // Start
        8'hFF,                              // Segment address
        8'h00, 8'h8B, 8'hFC, 8'h7B,         // Data 0..3
        8'h00, 8'h00, 8'h00, 8'h07,         // Data 4..7
        8'h00, 8'h00, 8'h00, 8'h00,         // Data 8..11
        8'h00, 8'h00, 8'h00, 8'h07,         // Data 12..15
        `EVG_K_SEG_STOP,                    // Stop
        8'hFC, 8'hF0,                       // Checksum
        8'h00, 8'h00, 8'h00, 8'h00,         // Padding to table length
        8'h00, 8'h00, 8'h00, 8'h00,
        8'h00, 8'h00, 8'h00
    };

endpackage

// ==== src/event_source.sv ====
`timescale 1ns/1ps

module event_source (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 clear_i,   // Restarts the code sequence while high
    input  evg_pkg::presc_t      presc_i,
    input  logic                 full_i,
    output logic                 wr_en_o,
    output evg_pkg::event_code_t event_o
);
    import evg_pkg::*;

    presc_t      cnt_q;         // Prescaler counter
    event_code_t code_q;        // Code for the next write
    event_code_t next_code;
    logic        at_reload;

    // Greater-or-equal also recovers when presc_i is lowered below the count
    assign at_reload = (cnt_q >= presc_i);

    // Held off while full so the pending code waits instead of dropping
    assign wr_en_o = at_reload && !full_i && !clear_i;
    assign event_o = code_q;

    // Wrap FF back to 1 as zero is idle on the link
    assign next_code = (code_q == '1) ? event_code_t'(1) : code_q + 1'b1;

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cnt_q  <= '0;
            code_q <= event_code_t'(1);
        end
        else if (clear_i)
        begin
            cnt_q  <= '0;               // Restart period
            code_q <= event_code_t'(1); // Sequence starts at 1 again
        end
        else if (wr_en_o)
        begin
            cnt_q  <= '0;
            code_q <= next_code;
        end
        else if (!full_i)
        begin
            cnt_q <= cnt_q + 1'b1;
        end
        // Full at reload holds both
    end

    // Producer half of the full handshake
    assert property (@(posedge clk) disable iff (!rst_n_i) full_i |-> !wr_en_o)
        else $error("event_source: write strobe while FIFO full");

endmodule

// ==== src/event_fifo.sv ====
`timescale 1ns/1ps
`include "evg_defs.svh"

module event_fifo #(
    parameter int DEPTH = `EVG_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 clear_i,   // Synchronous empty
    input  logic                 wr_en_i,
    input  evg_pkg::event_code_t wr_data_i,
    input  logic                 rd_en_i,
    output evg_pkg::event_code_t rd_data_o, // Head entry valid while not empty
    output logic                 empty_o,
    output logic                 full_o
);
    import evg_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    event_code_t      mem [0:DEPTH-1];  // Circular storage
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;          // Occupancy
    logic             do_wr;
    logic             do_rd;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));

    // Qualified strobes keep pointers and count consistent
    assign do_wr = wr_en_i && !full_o;
    assign do_rd = rd_en_i && !empty_o;

    assign rd_data_o = mem[rd_ptr_q];   // First word falls through

    // Payload storage
    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr_q] <= wr_data_i;
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else if (clear_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            if (do_rd)
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;

            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // Idle or push and pop together
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i) !(wr_en_i && full_o))
        else $error("event_fifo: write while full");

    assert property (@(posedge clk) disable iff (!rst_n_i) !(rd_en_i && empty_o))
        else $error("event_fifo: read while empty");

    // Write into an empty buffer shows at the head on the next cycle
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (wr_en_i && empty_o && !clear_i) |=> (!empty_o && rd_data_o == $past(wr_data_i)))
        else $error("event_fifo: written entry not at head one cycle later");

endmodule

// ==== src/link_frame_gen.sv ====
`timescale 1ns/1ps
`include "evg_defs.svh"

module link_frame_gen (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 link_ready_i,  // Link up level
    input  logic                 empty_i,
    input  evg_pkg::event_code_t event_i,       // FIFO head
    output logic                 rd_en_o,
    output evg_pkg::link_word_t  tx_word_o      // Registered link word
);
    import evg_pkg::*;

    logic [`EVG_SLOT_W-1:0] slot_q;     // Slot counter held at 0 while link down
    logic [`EVG_SLOT_W-2:0] seg_idx;    // Table index is slot / 2
    logic [7:0]             seg_byte;
    logic                   comma_slot;
    logic                   seg_slot;
    link_word_t             word_d;

    assign comma_slot = (slot_q[1:0] == 2'b00);    // Every fourth word
    assign seg_slot   = slot_q[0];                  // Odd slots carry the buffer
    assign seg_idx    = slot_q[`EVG_SLOT_W-1:1];
    assign seg_byte   = SEG_TABLE[seg_idx];

    // Pop the head on any non-comma slot with data waiting
    assign rd_en_o = link_ready_i && !comma_slot && !empty_i;

    // Word for the current slot
    always_comb
    begin
        word_d = '0;    // Idle word while link down
        if (link_ready_i)
        begin
            // Event lane
            if (comma_slot)
            begin
                word_d.ev_byte = `EVG_K_COMMA;
                word_d.ev_is_k = 1'b1;
            end
            else if (rd_en_o)
            begin
                word_d.ev_byte = event_i;
            end

            // Segment lane with the zero distributed bus on even slots
            if (seg_slot)
            begin
                word_d.seg_byte = seg_byte;
                word_d.seg_is_k = (seg_byte == `EVG_K_SEG_START) ||
                                  (seg_byte == `EVG_K_SEG_STOP);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            slot_q    <= '0;
            tx_word_o <= '0;
        end
        else
        begin
            tx_word_o <= word_d;            // Slot s leaves one cycle later
            if (link_ready_i)
                slot_q <= slot_q + 1'b1;    // Wraps after 63
            else
                slot_q <= '0;
        end
    end

    // Popped code lands on the event lane as nonzero data and never under a comma
    assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_en_o |=> (!tx_word_o.ev_is_k && tx_word_o.ev_byte == $past(event_i) &&
                     tx_word_o.ev_byte != '0))
        else $error("link_frame_gen: popped event not sent as data");

endmodule

// ==== src/evg_link_top.sv ====
`timescale 1ns/1ps

module evg_link_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                clear_i,        // Empties the buffer, codes restart at 1
    input  evg_pkg::presc_t     presc_i,        // Event period minus one
    input  logic                link_ready_i,
    output evg_pkg::link_word_t tx_word_o
);
    import evg_pkg::*;

    // Producer to buffer
    logic        wr_en;
    event_code_t wr_code;
    logic        full;

    // Buffer to frame generator
    logic        rd_en;
    event_code_t head_code;
    logic        empty;

    event_source event_source_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clear_i (clear_i),
        .presc_i (presc_i),
        .full_i  (full),
        .wr_en_o (wr_en),
        .event_o (wr_code)
    );

    event_fifo event_fifo_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .clear_i   (clear_i),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_code),
        .rd_en_i   (rd_en),
        .rd_data_o (head_code),
        .empty_o   (empty),
        .full_o    (full)
    );

    link_frame_gen link_frame_gen_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .link_ready_i (link_ready_i),
        .empty_i      (empty),
        .event_i      (head_code),
        .rd_en_o      (rd_en),
        .tx_word_o    (tx_word_o)
    );

endmodule

// ==== sim/tb_evg_link.sv ====
`timescale 1ns/1ps
`include "evg_defs.svh"

module tb_evg_link;
    import evg_pkg::*;

    localparam int NUM_ROWS    = 6;
    localparam int DRIVE_DELAY = 10;    // ns after the rising edge
    localparam int EVENT_WAIT  = 200;   // Cycles allowed for a row's first event

    // One stimulus row, the name lives in row_names
    typedef struct packed {
        presc_t      presc;
        logic        clear_before;  // One-cycle clear pulse first
        logic [7:0]  gap_max;       // Link-down gap 1..gap_max, 0 for none
        logic [15:0] cycles;        // Link-up cycles
        logic        expect_full;   // Back-pressure must show
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       clear;
    presc_t     presc;
    logic       link_ready;
    link_word_t tx_word;

    row_t  rows [NUM_ROWS];
    string row_names [NUM_ROWS];

    // Reference model state
    string       test_name;
    logic [31:0] rnd_state;
    logic [5:0]  slot;          // Slot of the next link-up word
    event_code_t exp_code;      // Next code expected on the event lane
    logic        lr_prev;       // Link-ready level seen by the coming edge
    logic        clr_prev;      // Clear level seen by the coming edge
    int          events_seen;
    logic        full_seen;
    logic        wrapped;       // Sequence went FF to 1 at least once

    evg_link_top evg_link_top_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .clear_i      (clear),
        .presc_i      (presc),
        .link_ready_i (link_ready),
        .tx_word_o    (tx_word)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Successor in the event sequence, zero skipped
    function automatic event_code_t code_after(input event_code_t c);
        return (c == 8'hFF) ? 8'h01 : c + 8'h01;
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            stop_on_failure($sformatf("error: test %s, %s expected %0h actual %0h",
                                      test_name, field, expected, actual));
    endtask

    // Compare the word on the link with the model, then advance the model
    task automatic check_word();
        logic [7:0] exp_seg;
        logic       exp_seg_k;
        if (!lr_prev)
        begin
            check_value("idle word", 32'h0, 32'({14'b0, tx_word}));
            slot = '0;                  // Next link-up word is slot 0
        end
        else
        begin
            if (slot[1:0] == 2'b00)     // Comma every fourth word
            begin
                check_value("comma byte", 32'(`EVG_K_COMMA), 32'(tx_word.ev_byte));
                check_value("comma K flag", 32'h1, 32'(tx_word.ev_is_k));
            end
            else
            begin
                check_value("event K flag", 32'h0, 32'(tx_word.ev_is_k));
                if (tx_word.ev_byte != 8'h00)   // Zero is idle
                begin
                    check_value("event code", 32'(exp_code), 32'(tx_word.ev_byte));
                    if (exp_code == 8'hFF)
                        wrapped = 1'b1;
                    exp_code = code_after(exp_code);
                    events_seen++;
                end
            end
            // Segment lane, table byte on odd slots only
            if (slot[0])
                exp_seg = SEG_TABLE[(int'(slot) / 2) % `EVG_SEG_WORDS];
            else
                exp_seg = 8'h00;
            exp_seg_k = slot[0] &&
                        (exp_seg == `EVG_K_SEG_START || exp_seg == `EVG_K_SEG_STOP);
            check_value("segment byte", 32'(exp_seg), 32'(tx_word.seg_byte));
            check_value("segment K flag", 32'(exp_seg_k), 32'(tx_word.seg_is_k));
            slot = slot + 6'd1;         // Wraps after 63
        end
    endtask

    // One clock: check the new word, then drive the next inputs
    task automatic run_cycle(input logic lr, input logic clr);
        @(posedge clk);
        #(DRIVE_DELAY);
        if (evg_link_top_i.full)
            full_seen = 1'b1;
        check_word();
        if (clr_prev)
            exp_code = 8'h01;           // Words after the clear edge restart at 1
        link_ready = lr;
        clear      = clr;
        lr_prev    = lr;
        clr_prev   = clr;
    endtask

    task automatic wait_for_event(input int start_count);
        int waited;
        waited = 0;
        while (events_seen == start_count && waited < EVENT_WAIT)
        begin
            run_cycle(1'b1, 1'b0);
            waited++;
        end
        if (events_seen == start_count)
            stop_on_failure($sformatf("timeout: test %s put no event code on the link in %0d cycles",
                                      test_name, EVENT_WAIT));
    endtask

    task automatic load_table();
        // presc, clear_before, gap_max, cycles, expect_full
        rows[0]      = '{32'd9, 1'b0, 8'd4, 16'd200, 1'b0};
        row_names[0] = "slow_after_reset";
        rows[1]      = '{32'd5, 1'b0, 8'd20, 16'd150, 1'b0};
        row_names[1] = "slow_with_gap";
        rows[2]      = '{32'd0, 1'b0, 8'd8, 16'd420, 1'b1};    // Runs past FF
        row_names[2] = "full_rate_wrap";
        rows[3]      = '{32'd2, 1'b1, 8'd0, 16'd100, 1'b0};
        row_names[3] = "clear_restart";
        rows[4]      = '{32'd0, 1'b0, 8'd30, 16'd120, 1'b1};
        row_names[4] = "gap_mid_burst";
        rows[5]      = '{32'd1, 1'b1, 8'd6, 16'd80, 1'b0};     // Clear with a full FIFO
        row_names[5] = "clear_after_burst";
    endtask

    initial
    begin
        int start_count;
        int gap;
        rst_n       = 1'b0;
        clear       = 1'b0;
        presc       = '0;
        link_ready  = 1'b0;
        rnd_state   = 32'h6905a297;
        slot        = '0;
        exp_code    = 8'h01;
        lr_prev     = 1'b0;
        clr_prev    = 1'b0;
        events_seen = 0;
        full_seen   = 1'b0;
        wrapped     = 1'b0;
        test_name   = "reset";
        load_table();

        repeat (2) @(posedge clk);      // Reset held 2 cycles
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        check_value("word after reset", 32'h0, 32'({14'b0, tx_word}));

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            test_name   = row_names[i];
            presc       = rows[i].presc;
            full_seen   = 1'b0;
            start_count = events_seen;
            if (rows[i].clear_before)
                run_cycle(link_ready, 1'b1);    // Link level kept
            gap = 0;
            if (rows[i].gap_max != 8'd0)
            begin
                rnd_state = xorshift(rnd_state);
                gap = 1 + int'(rnd_state % 32'(rows[i].gap_max));
            end
            repeat (gap) run_cycle(1'b0, 1'b0);
            repeat (rows[i].cycles) run_cycle(1'b1, 1'b0);
            wait_for_event(start_count);
            if (rows[i].expect_full)
                check_value("FIFO full seen", 32'h1, 32'(full_seen));
        end

        test_name = "sequence";
        check_value("code wrap FF to 1", 32'h1, 32'(wrapped));
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+src
src/evg_pkg.sv
src/event_source.sv
src/event_fifo.sv
src/link_frame_gen.sv
src/evg_link_top.sv
sim/tb_evg_link.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the event link testbench with Verilator and runs it
# The result is taken from the pass message in sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_evg_link -f project.f \
    && ./obj_dir/Vtb_evg_link 2>&1 | tee sim.log \
    || { echo "Build or run failed"; exit 1; }

grep -q "SIMULATION PASSED" sim.log \
    && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }
